//--- hw/mbox_defines.svh
`ifndef MBOX_DEFINES_SVH
`define MBOX_DEFINES_SVH

// upstream channels and the field that selects one
`define MBOX_CHANNELS 8
`define MBOX_CHAN_W 3

`define MBOX_WORD_W 32

// upstream packet buffer, per channel
`define MBOX_UP_WORDS 512
`define MBOX_UP_AW 9

// downstream buffer
`define MBOX_DOWN_WORDS 512
`define MBOX_DOWN_AW 9

// byte length of a packet or transfer
`define MBOX_LEN_W 11

// host word address
`define MBOX_HOST_AW 16

`endif

//--- hw/mbox_host_pkg.sv
`default_nettype none
`include "mbox_defines.svh"

package mbox_host_pkg;

	// host address fields
	localparam int REGION_HI = 15;
	localparam int REGION_LO = 13;
	localparam int CHAN_LO = 9; // channel in PKT_REGION
	localparam int REG_IDX_W = 5;

	typedef enum logic [2:0] {
		REG_REGION  = 3'd0,
		PKT_REGION  = 3'd1,
		DOWN_REGION = 3'd2 // write only
	} region_e;

	// one LEN_BASE entry per channel and two TS_BASE entries (sec then nsec)
	typedef enum logic [REG_IDX_W-1:0] {
		FLAGS       = 5'd0,
		CLR         = 5'd1,
		DOWN_START  = 5'd2,
		DOWN_STATUS = 5'd3,
		LEN_BASE    = 5'd8,
		TS_BASE     = 5'd16
	} reg_e;

	typedef struct packed {
		logic                     wr;
		logic                     rd;
		logic [`MBOX_HOST_AW-1:0] addr;
		logic [`MBOX_WORD_W-1:0]  wdata;
	} host_req_t;

	typedef struct packed {
		logic                    valid;
		logic [`MBOX_WORD_W-1:0] rdata;
	} host_rsp_t;

endpackage

`default_nettype wire

//--- hw/mbox_dev_pkg.sv
`default_nettype none
`include "mbox_defines.svh"

package mbox_dev_pkg;

	typedef logic [`MBOX_WORD_W-1:0] word_t;

	typedef struct packed {
		logic [31:0] sec;
		logic [31:0] nsec;
	} ts_t;

	// one word into an upstream buffer
	typedef struct packed {
		logic                   valid;
		logic [`MBOX_CHAN_W-1:0] chan;
		logic [`MBOX_UP_AW-1:0]  addr;
		word_t                  data;
	} up_wr_t;

	// closes the packet of one channel
	typedef struct packed {
		logic                   valid;
		logic [`MBOX_CHAN_W-1:0] chan;
		logic [`MBOX_LEN_W-1:0]  len;
	} up_done_t;

	typedef struct packed {
		logic  valid;
		logic  last;
		word_t data;
	} down_beat_t;

endpackage

`default_nettype wire

//--- hw/mbox_ram.sv
`timescale 1ns/10ps
`default_nettype none
`include "mbox_defines.svh"

module mbox_ram #(
	parameter int DEPTH = `MBOX_UP_WORDS,
	parameter int AW = `MBOX_UP_AW
) (
	input  wire logic                    user_clk,
	input  wire logic                    we,
	input  wire logic [AW-1:0]           waddr,
	input  wire logic [`MBOX_WORD_W-1:0] wdata,
	input  wire logic [AW-1:0]           raddr,
	output logic      [`MBOX_WORD_W-1:0] rdata
);

	logic [`MBOX_WORD_W-1:0] mem [DEPTH];

	always_ff @(posedge user_clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// read data one cycle after raddr
	always_ff @(posedge user_clk) begin
		rdata <= mem[raddr];
	end

endmodule

`default_nettype wire

//--- hw/up_channel.sv
`timescale 1ns/10ps
`default_nettype none
`include "mbox_defines.svh"

module up_channel #(
	parameter int CHAN = 0
) (
	input  wire logic                   user_clk,
	input  wire logic                   rst,
	input  wire mbox_dev_pkg::up_wr_t   wr,
	input  wire mbox_dev_pkg::up_done_t done,
	input  wire mbox_dev_pkg::ts_t      dev_time,
	input  wire logic                   clr,
	input  wire logic [`MBOX_UP_AW-1:0] raddr,
	output mbox_dev_pkg::word_t         rdata,
	output logic                        full,
	output logic [`MBOX_LEN_W-1:0]      len,
	output mbox_dev_pkg::ts_t           ts
);

	logic wr_hit;
	logic done_hit;

	// buffer is locked while the host owns it
	assign wr_hit = wr.valid && int'(wr.chan) == CHAN && !full;
	assign done_hit = done.valid && int'(done.chan) == CHAN && !full;

	mbox_ram #(
		.DEPTH (`MBOX_UP_WORDS),
		.AW    (`MBOX_UP_AW)
	) u_ram (
		.user_clk (user_clk),
		.we       (wr_hit),
		.waddr    (wr.addr),
		.wdata    (wr.data),
		.raddr    (raddr),
		.rdata    (rdata)
	);

	////////////////////////////////////////////////////////////
	// full flag
	////////////////////////////////////////////////////////////
	always_ff @(posedge user_clk) begin
		if (rst) begin
			full <= 1'b0;
		end else if (clr) begin
			full <= 1'b0; // host clear beats a done
		end else if (done_hit) begin
			full <= 1'b1;
		end
	end

	always_ff @(posedge user_clk) begin
		if (done_hit && !clr) begin
			len <= done.len;
			ts <= dev_time;
		end
	end

endmodule

`default_nettype wire

//--- hw/down_sender.sv
`timescale 1ns/10ps
`default_nettype none
`include "mbox_defines.svh"

module down_sender (
	input  wire logic                     user_clk,
	input  wire logic                     rst,
	input  wire logic                     hwe,
	input  wire logic [`MBOX_DOWN_AW-1:0] hwaddr,
	input  wire mbox_dev_pkg::word_t      hwdata,
	input  wire logic                     start,
	input  wire logic [`MBOX_LEN_W-1:0]   len,
	output mbox_dev_pkg::down_beat_t      beat,
	output logic                          busy,
	output logic                          completed
);

	logic                      accept;
	logic [`MBOX_LEN_W:0]      len_round;
	logic [`MBOX_LEN_W-2:0]    cnt; // words still to read
	logic [`MBOX_DOWN_AW-1:0]  rd_addr;
	logic                      issuing;
	logic                      issue_last;
	logic                      beat_valid;
	logic                      beat_last;
	mbox_dev_pkg::word_t       rd_data;

	assign accept = start && !busy && len != '0;
	assign len_round = {1'b0, len} + 3; // bytes to words rounding up
	assign issue_last = issuing && cnt == 1;

	mbox_ram #(
		.DEPTH (`MBOX_DOWN_WORDS),
		.AW    (`MBOX_DOWN_AW)
	) u_ram (
		.user_clk (user_clk),
		.we       (hwe),
		.waddr    (hwaddr),
		.wdata    (hwdata),
		.raddr    (rd_addr),
		.rdata    (rd_data)
	);

	////////////////////////////////////////////////////////////
	// read engine
	////////////////////////////////////////////////////////////
	always_ff @(posedge user_clk) begin
		if (rst) begin
			issuing <= 1'b0;
			cnt <= '0;
			rd_addr <= '0;
		end else if (accept) begin
			issuing <= 1'b1;
			cnt <= len_round[`MBOX_LEN_W:2];
			rd_addr <= '0;
		end else if (issuing) begin
			issuing <= !issue_last;
			cnt <= cnt - 1'b1;
			rd_addr <= rd_addr + 1'b1;
		end
	end

	// valid and last ride along with the ram read
	always_ff @(posedge user_clk) begin
		if (rst) begin
			beat_valid <= 1'b0;
			beat_last <= 1'b0;
			busy <= 1'b0;
			completed <= 1'b0;
		end else begin
			beat_valid <= issuing;
			beat_last <= issue_last;
			completed <= beat_valid && beat_last;
			if (accept) begin
				busy <= 1'b1;
			end else if (beat_valid && beat_last) begin
				busy <= 1'b0;
			end
		end
	end

	assign beat = '{valid: beat_valid, last: beat_last, data: rd_data};

endmodule

`default_nettype wire

//--- hw/host_regs.sv
`timescale 1ns/10ps
`default_nettype none
`include "mbox_defines.svh"

module host_regs (
	input  wire logic                      user_clk,
	input  wire logic                      rst,
	input  wire mbox_host_pkg::host_req_t  req,
	output mbox_host_pkg::host_rsp_t       rsp,
	input  wire logic [`MBOX_CHANNELS-1:0] full,
	input  wire logic [`MBOX_LEN_W-1:0]    lens [`MBOX_CHANNELS],
	input  wire mbox_dev_pkg::ts_t         stamps [`MBOX_CHANNELS],
	input  wire mbox_dev_pkg::word_t       pkt_rdata [`MBOX_CHANNELS],
	output logic [`MBOX_UP_AW-1:0]         pkt_raddr,
	output logic [`MBOX_CHANNELS-1:0]      clr,
	output logic                           down_we,
	output logic                           down_start,
	output logic [`MBOX_LEN_W-1:0]         down_len,
	input  wire logic                      down_busy,
	input  wire logic                      down_completed
);

	mbox_host_pkg::region_e                 region;
	logic [mbox_host_pkg::REG_IDX_W-1:0]    idx;
	logic                                   reg_wr;
	logic                                   done_q;
	// stage 1 lines up with the packet ram read
	logic                                   s1_valid;
	mbox_host_pkg::region_e                 s1_region;
	logic [`MBOX_CHAN_W-1:0]                s1_chan;
	logic [mbox_host_pkg::REG_IDX_W-1:0]    s1_idx;
	mbox_dev_pkg::ts_t                      ts_sel;
	mbox_dev_pkg::word_t                    reg_rdata;
	mbox_dev_pkg::word_t                    mux_rdata;
	// stage 2
	logic                                   rsp_valid;
	mbox_dev_pkg::word_t                    rsp_rdata;

	assign region = mbox_host_pkg::region_e'(
		req.addr[mbox_host_pkg::REGION_HI:mbox_host_pkg::REGION_LO]);
	assign idx = req.addr[mbox_host_pkg::REG_IDX_W-1:0];
	assign reg_wr = req.wr && region == mbox_host_pkg::REG_REGION;

	////////////////////////////////////////////////////////////
	// write side
	////////////////////////////////////////////////////////////
	assign pkt_raddr = req.addr[`MBOX_UP_AW-1:0];
	assign clr = (reg_wr && idx == mbox_host_pkg::CLR) ? req.wdata[`MBOX_CHANNELS-1:0] : '0;
	assign down_we = req.wr && region == mbox_host_pkg::DOWN_REGION;
	assign down_start = reg_wr && idx == mbox_host_pkg::DOWN_START;
	assign down_len = req.wdata[`MBOX_LEN_W-1:0];

	// sticky done cleared by writing 1 to bit 1
	always_ff @(posedge user_clk) begin
		if (rst) begin
			done_q <= 1'b0;
		end else if (down_completed) begin
			done_q <= 1'b1;
		end else if (reg_wr && idx == mbox_host_pkg::DOWN_STATUS && req.wdata[1]) begin
			done_q <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////
	// read pipeline
	////////////////////////////////////////////////////////////
	always_ff @(posedge user_clk) begin
		if (rst) begin
			s1_valid <= 1'b0;
			rsp_valid <= 1'b0;
		end else begin
			s1_valid <= req.rd;
			rsp_valid <= s1_valid;
		end
	end

	always_ff @(posedge user_clk) begin
		s1_region <= region;
		s1_chan <= req.addr[mbox_host_pkg::CHAN_LO +: `MBOX_CHAN_W];
		s1_idx <= idx;
		rsp_rdata <= mux_rdata;
	end

	// index bits below assume 8 channels
	always_comb begin
		reg_rdata = '0;
		ts_sel = stamps[s1_idx[3:1]];
		if (s1_idx >= mbox_host_pkg::TS_BASE) begin
			reg_rdata = s1_idx[0] ? ts_sel.nsec : ts_sel.sec;
		end else if (s1_idx >= mbox_host_pkg::LEN_BASE) begin
			reg_rdata[`MBOX_LEN_W-1:0] = lens[s1_idx[2:0]];
		end else if (s1_idx == mbox_host_pkg::FLAGS) begin
			reg_rdata[`MBOX_CHANNELS-1:0] = full;
		end else if (s1_idx == mbox_host_pkg::DOWN_STATUS) begin
			// done shows in the same cycle that busy falls
			reg_rdata[1:0] = {done_q || down_completed, down_busy};
		end
	end

	always_comb begin
		case (s1_region)
			mbox_host_pkg::REG_REGION: mux_rdata = reg_rdata;
			mbox_host_pkg::PKT_REGION: mux_rdata = pkt_rdata[s1_chan];
			default:                   mux_rdata = '0; // down buffer not readable
		endcase
	end

	assign rsp = '{valid: rsp_valid, rdata: rsp_rdata};

endmodule

`default_nettype wire

//--- hw/mbox_top.sv
`timescale 1ns/10ps
`default_nettype none
`include "mbox_defines.svh"

module mbox_top (
	input  wire logic                     user_clk,
	input  wire logic                     rst,
	input  wire mbox_host_pkg::host_req_t host_req,
	output mbox_host_pkg::host_rsp_t      host_rsp,
	input  wire mbox_dev_pkg::up_wr_t     up_wr,
	input  wire mbox_dev_pkg::up_done_t   up_done,
	input  wire mbox_dev_pkg::ts_t        dev_time,
	output logic [`MBOX_CHANNELS-1:0]     up_full,
	output mbox_dev_pkg::down_beat_t      down_beat,
	output logic                          down_completed
);

	logic [`MBOX_LEN_W-1:0]   lens [`MBOX_CHANNELS];
	mbox_dev_pkg::ts_t        stamps [`MBOX_CHANNELS];
	mbox_dev_pkg::word_t      pkt_rdata [`MBOX_CHANNELS];
	logic [`MBOX_UP_AW-1:0]   pkt_raddr;
	logic [`MBOX_CHANNELS-1:0] clr;
	logic                     down_we;
	logic                     down_start;
	logic [`MBOX_LEN_W-1:0]   down_len;
	logic                     down_busy;

	////////////////////////////////////////////////////////////
	// upstream channels
	////////////////////////////////////////////////////////////
	for (genvar gi = 0; gi < `MBOX_CHANNELS; gi++) begin : g_chan
		up_channel #(.CHAN(gi)) u_chan (
			.user_clk (user_clk),
			.rst      (rst),
			.wr       (up_wr),
			.done     (up_done),
			.dev_time (dev_time),
			.clr      (clr[gi]),
			.raddr    (pkt_raddr),
			.rdata    (pkt_rdata[gi]),
			.full     (up_full[gi]),
			.len      (lens[gi]),
			.ts       (stamps[gi])
		);
	end

	down_sender u_sender (
		.user_clk  (user_clk),
		.rst       (rst),
		.hwe       (down_we),
		.hwaddr    (host_req.addr[`MBOX_DOWN_AW-1:0]),
		.hwdata    (host_req.wdata),
		.start     (down_start),
		.len       (down_len),
		.beat      (down_beat),
		.busy      (down_busy),
		.completed (down_completed)
	);

	host_regs u_regs (
		.user_clk       (user_clk),
		.rst            (rst),
		.req            (host_req),
		.rsp            (host_rsp),
		.full           (up_full),
		.lens           (lens),
		.stamps         (stamps),
		.pkt_rdata      (pkt_rdata),
		.pkt_raddr      (pkt_raddr),
		.clr            (clr),
		.down_we        (down_we),
		.down_start     (down_start),
		.down_len       (down_len),
		.down_busy      (down_busy),
		.down_completed (down_completed)
	);

endmodule

`default_nettype wire

//--- bench/mbox_checker.sv
`timescale 1ns/10ps
`default_nettype none
`include "mbox_defines.svh"

module mbox_checker (
	input wire logic                     user_clk,
	input wire logic                     rst,
	input wire mbox_host_pkg::host_req_t req,
	input wire mbox_host_pkg::host_rsp_t rsp,
	input wire logic                     start,
	input wire logic [`MBOX_LEN_W-1:0]   len,
	input wire logic                     busy,
	input wire mbox_dev_pkg::down_beat_t beat,
	input wire logic                     completed
);

	////////////////////////////////////////////////////////////
	// host read timing
	////////////////////////////////////////////////////////////
	a_rsp_after_rd: assert property (@(posedge user_clk) disable iff (rst)
		req.rd |-> ##2 rsp.valid)
		else $error("read response missing two cycles after rd");

	a_rsp_only_after_rd: assert property (@(posedge user_clk) disable iff (rst)
		rsp.valid |-> $past(req.rd, 2))
		else $error("read response without a matching rd");

	////////////////////////////////////////////////////////////
	// downstream stream
	////////////////////////////////////////////////////////////
	a_first_beat: assert property (@(posedge user_clk) disable iff (rst)
		start && !busy && len != '0 |-> ##2 beat.valid)
		else $error("first beat not two cycles after an accepted start");

	a_beats_contiguous: assert property (@(posedge user_clk) disable iff (rst)
		beat.valid && !beat.last |=> beat.valid)
		else $error("gap in the downstream beats");

	a_completed_after_last: assert property (@(posedge user_clk) disable iff (rst)
		beat.valid && beat.last |=> completed)
		else $error("completed missing one cycle after last beat");

	a_completed_only_after_last: assert property (@(posedge user_clk) disable iff (rst)
		completed |-> $past(beat.valid && beat.last))
		else $error("completed without a last beat");

	a_no_idle_beat: assert property (@(posedge user_clk) disable iff (rst)
		beat.valid |-> busy)
		else $error("beat while the sender is idle");

endmodule

bind mbox_top mbox_checker u_checker (
	.user_clk  (user_clk),
	.rst       (rst),
	.req       (host_req),
	.rsp       (host_rsp),
	.start     (down_start),
	.len       (down_len),
	.busy      (down_busy),
	.beat      (down_beat),
	.completed (down_completed)
);

`default_nettype wire

//--- bench/mbox_tb.sv
`timescale 1ns/10ps
`default_nettype none
`include "mbox_defines.svh"

module mbox_tb;

	logic                                user_clk;
	logic                                rst;
	mbox_host_pkg::host_req_t            host_req;
	mbox_host_pkg::host_rsp_t            host_rsp;
	mbox_dev_pkg::up_wr_t                up_wr;
	mbox_dev_pkg::up_done_t              up_done;
	mbox_dev_pkg::ts_t                   dev_time;
	logic [`MBOX_CHANNELS-1:0]           up_full;
	mbox_dev_pkg::down_beat_t            down_beat;
	logic                                down_completed;

	// upstream reference model
	mbox_dev_pkg::word_t       exp_pkt [`MBOX_CHANNELS][`MBOX_UP_WORDS];
	int                        exp_words [`MBOX_CHANNELS];
	logic [`MBOX_LEN_W-1:0]    exp_len [`MBOX_CHANNELS];
	mbox_dev_pkg::ts_t         exp_ts [`MBOX_CHANNELS];
	logic [`MBOX_CHANNELS-1:0] exp_full;
	mbox_dev_pkg::word_t       exp_down [`MBOX_DOWN_WORDS];
	// captured downstream stream
	mbox_dev_pkg::word_t       got_data [$];
	int                        first_at;
	int                        last_at;
	int                        lasts;
	int                        done_at;
	int                        pulses;
	logic [31:0]               rand_state;
	int                        err_cnt;
	int                        test_cnt;
	int                        fail_tests;

	mbox_top u_dut (
		.user_clk       (user_clk),
		.rst            (rst),
		.host_req       (host_req),
		.host_rsp       (host_rsp),
		.up_wr          (up_wr),
		.up_done        (up_done),
		.dev_time       (dev_time),
		.up_full        (up_full),
		.down_beat      (down_beat),
		.down_completed (down_completed)
	);

	always #5 user_clk = ~user_clk;

	function automatic logic [31:0] next_rand();
		rand_state ^= rand_state << 13;
		rand_state ^= rand_state >> 17;
		rand_state ^= rand_state << 5;
		return rand_state;
	endfunction

	function automatic logic [`MBOX_HOST_AW-1:0] reg_addr(input int idx);
		return {mbox_host_pkg::REG_REGION, 8'd0, 5'(idx)};
	endfunction

	function automatic logic [`MBOX_HOST_AW-1:0] pkt_addr(input int chan, input int word);
		return {mbox_host_pkg::PKT_REGION, 1'b0, 3'(chan), 9'(word)};
	endfunction

	function automatic logic [`MBOX_HOST_AW-1:0] down_addr(input int word);
		return {mbox_host_pkg::DOWN_REGION, 4'd0, 9'(word)};
	endfunction

	task automatic step();
		@(posedge user_clk);
		#1;
	endtask

	////////////////////////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////////////////////////
	task automatic check_word(input string name, input mbox_dev_pkg::word_t exp,
			input mbox_dev_pkg::word_t act);
		if (act !== exp) begin
			$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
			err_cnt++;
		end
	endtask

	task automatic check_len(input string name, input logic [`MBOX_LEN_W-1:0] exp,
			input logic [`MBOX_LEN_W-1:0] act);
		if (act !== exp) begin
			$display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
			err_cnt++;
		end
	endtask

	task automatic check_ts(input string name, input mbox_dev_pkg::ts_t exp,
			input mbox_dev_pkg::ts_t act);
		if (act !== exp) begin
			$display("[ERROR] %s: expected %0d.%09d, actual %0d.%09d", name,
				exp.sec, exp.nsec, act.sec, act.nsec);
			err_cnt++;
		end
	endtask

	task automatic check_flags(input string name, input logic [`MBOX_CHANNELS-1:0] exp,
			input logic [`MBOX_CHANNELS-1:0] act);
		if (act !== exp) begin
			$display("[ERROR] %s: expected %b, actual %b", name, exp, act);
			err_cnt++;
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			$display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
			err_cnt++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// bus and device drivers
	////////////////////////////////////////////////////////////
	task automatic host_write(input logic [`MBOX_HOST_AW-1:0] addr, input logic [31:0] data);
		host_req = '{wr: 1'b1, rd: 1'b0, addr: addr, wdata: data};
		step();
		host_req = '0;
	endtask

	task automatic host_read(input logic [`MBOX_HOST_AW-1:0] addr,
			output mbox_dev_pkg::word_t data);
		int n;
		host_req = '{wr: 1'b0, rd: 1'b1, addr: addr, wdata: '0};
		step();
		host_req = '0;
		for (n = 0; n < 8 && !host_rsp.valid; n++) begin
			step();
		end
		if (!host_rsp.valid) begin
			$display("timeout: no read response for address %h", addr);
			err_cnt++;
		end
		data = host_rsp.rdata;
	endtask

	task automatic host_clear(input logic [`MBOX_CHANNELS-1:0] mask);
		host_write(reg_addr(mbox_host_pkg::CLR), 32'(mask));
		exp_full &= ~mask;
	endtask

	// writes and done are dropped while the channel is full
	task automatic dev_write_packet(input int chan, input int n,
			input logic [`MBOX_LEN_W-1:0] len, input mbox_dev_pkg::ts_t ts);
		int i;
		mbox_dev_pkg::word_t data;
		for (i = 0; i < n; i++) begin
			data = next_rand();
			up_wr = '{valid: 1'b1, chan: 3'(chan), addr: 9'(i), data: data};
			if (!exp_full[chan]) begin
				exp_pkt[chan][i] = data;
			end
			step();
		end
		up_wr = '0;
		up_done = '{valid: 1'b1, chan: 3'(chan), len: len};
		dev_time = ts;
		if (!exp_full[chan]) begin
			exp_words[chan] = n;
			exp_len[chan] = len;
			exp_ts[chan] = ts;
			exp_full[chan] = 1'b1;
		end
		step();
		up_done = '0;
	endtask

	task automatic verify_flags(input string name, input logic [`MBOX_CHANNELS-1:0] exp);
		mbox_dev_pkg::word_t rd;
		check_flags({name, " up_full"}, exp, up_full);
		host_read(reg_addr(mbox_host_pkg::FLAGS), rd);
		check_flags({name, " FLAGS"}, exp, rd[`MBOX_CHANNELS-1:0]);
	endtask

	task automatic verify_channel(input int chan);
		int i;
		mbox_dev_pkg::word_t rd;
		mbox_dev_pkg::ts_t ts;
		host_read(reg_addr(mbox_host_pkg::LEN_BASE + chan), rd);
		check_len($sformatf("chan %0d length", chan), exp_len[chan], rd[`MBOX_LEN_W-1:0]);
		host_read(reg_addr(mbox_host_pkg::TS_BASE + 2 * chan), rd);
		ts.sec = rd;
		host_read(reg_addr(mbox_host_pkg::TS_BASE + 2 * chan + 1), rd);
		ts.nsec = rd;
		check_ts($sformatf("chan %0d timestamp", chan), exp_ts[chan], ts);
		for (i = 0; i < exp_words[chan]; i++) begin
			host_read(pkt_addr(chan, i), rd);
			check_word($sformatf("chan %0d word %0d", chan, i), exp_pkt[chan][i], rd);
		end
	endtask

	task automatic load_down(input int n);
		int i;
		for (i = 0; i < n; i++) begin
			exp_down[i] = next_rand();
			host_write(down_addr(i), exp_down[i]);
		end
	endtask

	// index 0 is the sample right after the start edge
	task automatic collect_beats(input int limit);
		int i;
		got_data.delete();
		first_at = -1;
		last_at = -1;
		lasts = 0;
		done_at = -1;
		pulses = 0;
		for (i = 0; i < limit; i++) begin
			if (down_beat.valid) begin
				if (first_at < 0) begin
					first_at = i;
				end
				got_data.push_back(down_beat.data);
				if (down_beat.last) begin
					last_at = i;
					lasts++;
				end
			end
			if (down_completed) begin
				pulses++;
				done_at = i;
			end
			if (done_at >= 0 && i >= done_at + 4) begin
				break; // a few quiet cycles to catch extra beats
			end
			step();
		end
		if (done_at < 0) begin
			$display("timeout: downstream transfer did not complete within %0d cycles", limit);
			err_cnt++;
		end
	endtask

	task automatic count_activity(input int cycles, output int beats, output int seen);
		int i;
		beats = 0;
		seen = 0;
		for (i = 0; i < cycles; i++) begin
			if (down_beat.valid) begin
				beats++;
			end
			if (down_completed) begin
				seen++;
			end
			step();
		end
	endtask

	task automatic check_stream(input string name, input int n);
		int i;
		check_count({name, " beats"}, n, got_data.size());
		for (i = 0; i < n && i < got_data.size(); i++) begin
			check_word($sformatf("%s beat %0d", name, i), exp_down[i], got_data[i]);
		end
		check_count({name, " first beat cycle"}, 1, first_at);
		check_count({name, " last flags"}, 1, lasts);
		check_count({name, " last position"}, first_at + n - 1, last_at);
		check_count({name, " completed pulses"}, 1, pulses);
		check_count({name, " completed cycle"}, last_at + 1, done_at);
	endtask

	task automatic report_test(input string name, input int errs_before);
		test_cnt++;
		if (err_cnt == errs_before) begin
			$display("test %s: ok", name);
		end else begin
			fail_tests++;
			$display("test %s: %0d errors", name, err_cnt - errs_before);
		end
	endtask

	////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////
	task automatic test_reset_state();
		int errs;
		int beats;
		int seen;
		mbox_dev_pkg::word_t rd;
		errs = err_cnt;
		verify_flags("reset", '0);
		host_read(reg_addr(mbox_host_pkg::DOWN_STATUS), rd);
		check_word("reset DOWN_STATUS", 32'h0, rd);
		count_activity(20, beats, seen);
		check_count("reset beats", 0, beats);
		check_count("reset completed pulses", 0, seen);
		report_test("reset_state", errs);
	endtask

	task automatic test_single_channel();
		int errs;
		errs = err_cnt;
		dev_write_packet(3, 7, 11'd27, '{sec: 32'd4660, nsec: 32'd999_999_000});
		verify_flags("single", 8'b0000_1000);
		verify_channel(3);
		host_clear(8'b0000_1000);
		report_test("single_channel", errs);
	endtask

	task automatic test_all_channels();
		int errs;
		int c;
		int n;
		errs = err_cnt;
		for (c = 0; c < `MBOX_CHANNELS; c++) begin
			n = 1 + int'(next_rand() % 16);
			dev_write_packet(c, n, 11'(4 * n - int'(next_rand() % 4)),
				'{sec: next_rand(), nsec: next_rand()});
		end
		verify_flags("all filled", 8'hff);
		for (c = 0; c < `MBOX_CHANNELS; c++) begin
			verify_channel(c);
		end
		host_clear(8'b0010_0101);
		verify_flags("after clear", 8'b1101_1010);
		report_test("all_channels", errs);
	endtask

	task automatic test_full_protection();
		int errs;
		errs = err_cnt;
		dev_write_packet(1, 5, 11'd17, '{sec: 32'd77, nsec: 32'd123});
		verify_flags("while full", exp_full);
		verify_channel(1);
		host_clear(8'b0000_0010);
		dev_write_packet(1, 6, 11'd22, '{sec: 32'd78, nsec: 32'd456});
		verify_flags("refilled", exp_full);
		verify_channel(1);
		report_test("full_protection", errs);
	endtask

	task automatic test_downstream();
		int errs;
		mbox_dev_pkg::word_t rd;
		errs = err_cnt;
		load_down(4);
		host_write(reg_addr(mbox_host_pkg::DOWN_START), 32'd13); // 13 bytes -> 4 words
		collect_beats(100);
		check_stream("down", 4);
		host_read(reg_addr(mbox_host_pkg::DOWN_STATUS), rd);
		check_word("down status after transfer", 32'h2, rd);
		host_write(reg_addr(mbox_host_pkg::DOWN_STATUS), 32'h2);
		host_read(reg_addr(mbox_host_pkg::DOWN_STATUS), rd);
		check_word("down status after clear", 32'h0, rd);
		report_test("downstream", errs);
	endtask

	task automatic test_start_while_busy();
		int errs;
		int beats;
		int seen;
		mbox_dev_pkg::word_t rd;
		errs = err_cnt;
		load_down(10);
		host_write(reg_addr(mbox_host_pkg::DOWN_START), 32'd40);
		fork
			collect_beats(100);
			begin
				step();
				step();
				host_write(reg_addr(mbox_host_pkg::DOWN_START), 32'd20); // sender busy
				host_read(reg_addr(mbox_host_pkg::DOWN_STATUS), rd);
				check_word("busy start status", 32'h1, rd);
			end
		join
		check_stream("busy start", 10);
		host_write(reg_addr(mbox_host_pkg::DOWN_STATUS), 32'h2);
		host_write(reg_addr(mbox_host_pkg::DOWN_START), 32'd0);
		count_activity(20, beats, seen);
		check_count("zero length beats", 0, beats);
		check_count("zero length completed pulses", 0, seen);
		report_test("start_while_busy", errs);
	endtask

	initial begin
		user_clk = 1'b0;
		rst = 1'b1;
		host_req = '0;
		up_wr = '0;
		up_done = '0;
		dev_time = '0;
		rand_state = 32'd8;
		err_cnt = 0;
		test_cnt = 0;
		fail_tests = 0;
		exp_full = '0;
		for (int c = 0; c < `MBOX_CHANNELS; c++) begin
			exp_words[c] = 0;
		end
		repeat (5) @(posedge user_clk);
		#1;
		rst = 1'b0;
		test_reset_state();
		test_single_channel();
		test_all_channels();
		test_full_protection();
		test_downstream();
		test_start_while_busy();
		$display("tests %0d, failed %0d, errors %0d", test_cnt, fail_tests, err_cnt);
		if (err_cnt == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
+incdir+hw
hw/mbox_host_pkg.sv
hw/mbox_dev_pkg.sv
hw/mbox_ram.sv
hw/up_channel.sv
hw/down_sender.sv
hw/host_regs.sv
hw/mbox_top.sv
bench/mbox_checker.sv
bench/mbox_tb.sv

//--- Makefile
# Verilator build and run of the mailbox testbench

VERILATOR ?= verilator
TOP       ?= mbox_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard hw/*.sv hw/*.svh bench/*.sv)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "test failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "STATUS: PASS" $(LOG); then echo "run ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
